// File: common/cpu_defs.svh
`ifndef CPU_DEFS_SVH
`define CPU_DEFS_SVH

// --------------------------------------------------
// Datapath widths
// --------------------------------------------------
`define CPU_WORD_W      16  // Data and instruction word
`define CPU_ADDR_W      16  // Memory and PC address

// --------------------------------------------------
// Register file size
// --------------------------------------------------
`define CPU_REG_N       8   // Number of general registers
`define CPU_REG_SEL_W   3   // Bits to pick one register

// Sequencer state encoding width
`define CPU_STATE_W     3

`endif

// File: common/isa_pkg.sv
`default_nettype none

`include "cpu_defs.svh"

package isa_pkg;

    typedef logic [`CPU_WORD_W-1:0]    word_t;     // Data or instruction word
    typedef logic [`CPU_ADDR_W-1:0]    addr_t;     // Memory or PC address
    typedef logic [`CPU_REG_SEL_W-1:0] reg_sel_t;  // Register number

    // Opcodes live in IR[15:12]
    typedef enum logic [3:0] {
        OP_NOP = 4'h0,
        OP_LDI = 4'h1,  // Dest <= zero-extended IR[8:0]
        OP_LD  = 4'h2,  // Dest <= mem[IR[8:0]]
        OP_ST  = 4'h3,  // mem[IR[8:0]] <= Dest
        OP_STX = 4'h4,  // mem[reg[src2]] <= reg[dest]
        OP_JPL = 4'h5,  // IR[11] high means JMP, no link
        OP_RET = 4'h6,
        OP_BRD = 4'h7,  // PC relative, IR[9:0] offset
        OP_BRX = 4'h8,  // Target in reg[src1]
        OP_ADD = 4'h9,
        OP_SUB = 4'ha,
        OP_AND = 4'hb,
        OP_OR  = 4'hc,
        OP_XOR = 4'hd,
        OP_HLT = 4'hf
    } opcode_e;

    // Branch condition, IR[11:10]
    typedef enum logic [1:0] {
        BEQ = 2'b00,
        BNE = 2'b01,
        BLT = 2'b10,
        BCS = 2'b11
    } branch_cond_e;

    typedef enum logic [2:0] {
        ALU_ADD,
        ALU_SUB,
        ALU_AND,
        ALU_OR,
        ALU_XOR
    } alu_op_e;

    typedef struct packed {
        logic z;    // Zero
        logic c;    // Carry, or borrow after SUB
        logic n;    // Sign
        logic v;    // Signed overflow
    } flags_t;

endpackage

`default_nettype wire

// File: common/ctrl_pkg.sv
`default_nettype none

`include "cpu_defs.svh"

package ctrl_pkg;

    typedef enum logic [`CPU_STATE_W-1:0] {
        FETCH_ADDR,     // PC onto the bus
        FETCH_DATA,     // IR <= mem_rdata, PC + 1
        DECODE,
        EXECUTE,        // LD and ALU write-back only
        IDLE            // Halted until reset
    } seq_state_e;

    // PC load source
    typedef enum logic [1:0] {
        PC_REL,         // PC + sign-extended IR[9:0]
        PC_REG,         // Read port 1
        PC_LINK         // Return address
    } pc_src_e;

    // Memory address source
    typedef enum logic [1:0] {
        ADDR_PC,
        ADDR_IMM,       // Zero-extended IR[8:0]
        ADDR_REG2       // Read port 2
    } addr_src_e;

    // Register file write data
    typedef enum logic [1:0] {
        DATA_IMM,
        DATA_MEM,
        DATA_ALU
    } data_src_e;

    typedef enum logic {
        RD1_DEST,       // IR[11:9]
        RD1_SRC1        // IR[6:4]
    } rd1_sel_e;

endpackage

`default_nettype wire

// File: common/cpu_ctrl_if.sv
`timescale 1ns/100ps
`default_nettype none

interface cpu_ctrl_if import isa_pkg::*, ctrl_pkg::*; ();

    // Datapath status
    word_t       instr;     // Current IR
    flags_t      flags;

    // Sequencer controls
    logic        ir_ld;
    logic        pc_inc;
    logic        pc_ld;
    pc_src_e     pc_src;
    logic        link_ld;
    addr_src_e   addr_src;
    logic        mem_en;
    logic        mem_we;
    logic        reg_we;
    data_src_e   data_src;
    rd1_sel_e    rd1_sel;
    alu_op_e     alu_op;
    logic        alu_ld;    // Latch ALU result
    logic        flg_ld;    // Latch ALU flags
    logic        flg_rst;   // Clear flags after a branch

    modport sequencer (
        input  instr, flags,
        output ir_ld, pc_inc, pc_ld, pc_src, link_ld, addr_src, mem_en, mem_we,
               reg_we, data_src, rd1_sel, alu_op, alu_ld, flg_ld, flg_rst
    );

    modport datapath (
        output instr, flags,
        input  ir_ld, pc_inc, pc_ld, pc_src, link_ld, addr_src, mem_en, mem_we,
               reg_we, data_src, rd1_sel, alu_op, alu_ld, flg_ld, flg_rst
    );

endinterface

`default_nettype wire

// File: logic/reg_file.sv
`timescale 1ns/100ps
`default_nettype none

`include "cpu_defs.svh"

module reg_file import isa_pkg::*; (
    input  wire logic     Clk,
    input  wire logic     we,
    input  wire reg_sel_t waddr,
    input  wire word_t    wdata,
    input  wire reg_sel_t raddr1,
    input  wire reg_sel_t raddr2,
    output word_t         rdata1,
    output word_t         rdata2
);

    word_t regs [`CPU_REG_N];   // No hardwired zero register

    // Single write port
    always_ff @(posedge Clk) begin
        if (we) begin
            regs[waddr] <= wdata;
        end
    end

    // Asynchronous reads
    assign rdata1 = regs[raddr1];
    assign rdata2 = regs[raddr2];

endmodule

`default_nettype wire

// File: logic/alu.sv
`timescale 1ns/100ps
`default_nettype none

module alu import isa_pkg::*; (
    input  wire word_t   a,
    input  wire alu_op_e op,
    input  wire word_t   b,
    output word_t        result,
    output flags_t       flags
);

    localparam int W = $bits(word_t);

    logic [W:0] wide;   // Extra bit for carry or borrow

    always_comb begin
        wide   = '0;
        result = '0;
        flags  = '0;     // Logic ops leave c and v clear

        case (op)
            ALU_ADD: begin
                wide    = {1'b0, a} + {1'b0, b};
                result  = wide[W-1:0];
                flags.c = wide[W];
                // Same signs in, other sign out
                flags.v = (a[W-1] == b[W-1]) && (result[W-1] != a[W-1]);
            end
            ALU_SUB: begin
                wide    = {1'b0, a} - {1'b0, b};
                result  = wide[W-1:0];
                flags.c = wide[W];             // Borrow, a below b unsigned
                flags.v = (a[W-1] != b[W-1]) && (result[W-1] != a[W-1]);
            end
            ALU_AND: result = a & b;
            ALU_OR:  result = a | b;
            ALU_XOR: result = a ^ b;
            default: result = '0;
        endcase

        flags.z = (result == '0);
        flags.n = result[W-1];
    end

endmodule

`default_nettype wire

// File: sequencer/sequence_control.sv
`timescale 1ns/100ps
`default_nettype none

module sequence_control import isa_pkg::*, ctrl_pkg::*; (
    input  wire logic     Clk,
    input  wire logic     reset,
    cpu_ctrl_if.sequencer ctrl,
    output logic          halted
);

    seq_state_e   state_q;
    seq_state_e   state_d;
    opcode_e      opcode;
    branch_cond_e cond;
    logic         take_branch;
    logic         alu_instr;    // Decoded op goes through the ALU

    assign opcode = opcode_e'(ctrl.instr[15:12]);
    assign cond   = branch_cond_e'(ctrl.instr[11:10]);
    assign halted = (state_q == IDLE);

    // --------------------------------------------------
    // Branch condition from the latched flags
    // --------------------------------------------------
    always_comb begin
        case (cond)
            BEQ:     take_branch = ctrl.flags.z;
            BNE:     take_branch = !ctrl.flags.z;
            BLT:     take_branch = ctrl.flags.n != ctrl.flags.v;  // Signed less than
            BCS:     take_branch = ctrl.flags.c;
            default: take_branch = 1'b0;
        endcase
    end

    // --------------------------------------------------
    // Control matrix
    // --------------------------------------------------
    always_comb begin
        // Defaults, all controls idle
        state_d       = state_q;
        alu_instr     = 1'b0;
        ctrl.ir_ld    = 1'b0;
        ctrl.pc_inc   = 1'b0;
        ctrl.pc_ld    = 1'b0;
        ctrl.pc_src   = PC_REL;
        ctrl.link_ld  = 1'b0;
        ctrl.addr_src = ADDR_PC;
        ctrl.mem_en   = 1'b0;
        ctrl.mem_we   = 1'b0;
        ctrl.reg_we   = 1'b0;
        ctrl.data_src = DATA_IMM;
        ctrl.rd1_sel  = RD1_DEST;
        ctrl.alu_op   = ALU_ADD;
        ctrl.alu_ld   = 1'b0;
        ctrl.flg_ld   = 1'b0;
        ctrl.flg_rst  = 1'b0;

        case (state_q)
            FETCH_ADDR: begin
                ctrl.mem_en   = 1'b1;       // Read at PC
                ctrl.addr_src = ADDR_PC;
                state_d       = FETCH_DATA;
            end

            FETCH_DATA: begin
                ctrl.ir_ld  = 1'b1;         // Word is on mem_rdata now
                ctrl.pc_inc = 1'b1;         // Bump PC on the same edge
                state_d     = DECODE;
            end

            DECODE: begin
                state_d = FETCH_ADDR;       // Most ops finish here
                case (opcode)
                    OP_NOP: ;
                    OP_HLT: state_d = IDLE;
                    OP_LDI: begin
                        ctrl.reg_we   = 1'b1;
                        ctrl.data_src = DATA_IMM;
                    end
                    OP_LD: begin
                        ctrl.mem_en   = 1'b1;   // Data back in EXECUTE
                        ctrl.addr_src = ADDR_IMM;
                        state_d       = EXECUTE;
                    end
                    OP_ST: begin
                        ctrl.mem_en   = 1'b1;
                        ctrl.mem_we   = 1'b1;
                        ctrl.addr_src = ADDR_IMM;
                        ctrl.rd1_sel  = RD1_DEST;   // Store data from dest field
                    end
                    OP_STX: begin
                        ctrl.mem_en   = 1'b1;
                        ctrl.mem_we   = 1'b1;
                        ctrl.addr_src = ADDR_REG2;  // Address from reg[src2]
                        ctrl.rd1_sel  = RD1_DEST;
                    end
                    OP_JPL: begin
                        ctrl.rd1_sel = RD1_SRC1;
                        ctrl.pc_src  = PC_REG;
                        ctrl.pc_ld   = 1'b1;
                        ctrl.link_ld = !ctrl.instr[11];  // JMP skips the link
                    end
                    OP_RET: begin
                        ctrl.pc_src = PC_LINK;
                        ctrl.pc_ld  = 1'b1;
                    end
                    OP_BRD: begin
                        ctrl.pc_src  = PC_REL;
                        ctrl.pc_ld   = take_branch;
                        ctrl.flg_rst = 1'b1;        // Flags are spent
                    end
                    OP_BRX: begin
                        ctrl.rd1_sel = RD1_SRC1;
                        ctrl.pc_src  = PC_REG;
                        ctrl.pc_ld   = take_branch;
                        ctrl.flg_rst = 1'b1;
                    end
                    OP_ADD: begin
                        alu_instr   = 1'b1;
                        ctrl.alu_op = ALU_ADD;
                    end
                    OP_SUB: begin
                        alu_instr   = 1'b1;
                        ctrl.alu_op = ALU_SUB;
                    end
                    OP_AND: begin
                        alu_instr   = 1'b1;
                        ctrl.alu_op = ALU_AND;
                    end
                    OP_OR: begin
                        alu_instr   = 1'b1;
                        ctrl.alu_op = ALU_OR;
                    end
                    OP_XOR: begin
                        alu_instr   = 1'b1;
                        ctrl.alu_op = ALU_XOR;
                    end
                    default: ;                  // Unused opcode acts as NOP
                endcase

                // Shared ALU setup, write-back in EXECUTE
                if (alu_instr) begin
                    ctrl.rd1_sel = RD1_SRC1;
                    ctrl.alu_ld  = 1'b1;
                    ctrl.flg_ld  = 1'b1;
                    state_d      = EXECUTE;
                end
            end

            EXECUTE: begin
                ctrl.reg_we   = 1'b1;
                ctrl.data_src = (opcode == OP_LD) ? DATA_MEM : DATA_ALU;
                state_d       = FETCH_ADDR;
            end

            IDLE: state_d = IDLE;           // Only reset leaves here

            default: state_d = FETCH_ADDR;
        endcase
    end

    // State register
    always_ff @(posedge Clk) begin
        if (reset) begin
            state_q <= FETCH_ADDR;
        end else begin
            state_q <= state_d;
        end
    end

endmodule

`default_nettype wire

// File: datapath/cpu_datapath.sv
`timescale 1ns/100ps
`default_nettype none

module cpu_datapath import isa_pkg::*, ctrl_pkg::*; (
    input  wire logic    Clk,
    input  wire logic    reset,
    cpu_ctrl_if.datapath ctrl,
    output addr_t        mem_addr,
    output word_t        mem_wdata,
    input  wire word_t   mem_rdata
);

    localparam int IMM_W  = 9;     // LDI, LD, ST immediate
    localparam int OFFS_W = 10;    // BRD offset

    addr_t    pc_q;
    addr_t    link_q;       // Single return address
    word_t    ir_q;
    word_t    alu_q;
    flags_t   flg_q;

    reg_sel_t dest;
    reg_sel_t src1;
    reg_sel_t src2;
    reg_sel_t raddr1;
    word_t    rdata1;
    word_t    rdata2;
    word_t    reg_wdata;
    word_t    alu_result;
    flags_t   alu_flags;
    addr_t    pc_rel;
    addr_t    pc_next;

    // Instruction fields
    assign dest   = ir_q[11:9];
    assign src1   = ir_q[6:4];
    assign src2   = ir_q[2:0];
    assign raddr1 = (ctrl.rd1_sel == RD1_SRC1) ? src1 : dest;

    assign ctrl.instr = ir_q;
    assign ctrl.flags = flg_q;
    assign mem_wdata  = rdata1;    // Stores always use port 1

    // PC is already incremented by the time BRD acts
    assign pc_rel = pc_q + {{($bits(addr_t)-OFFS_W){ir_q[OFFS_W-1]}}, ir_q[OFFS_W-1:0]};

    // --------------------------------------------------
    // Muxes
    // --------------------------------------------------
    always_comb begin
        case (ctrl.addr_src)
            ADDR_IMM:  mem_addr = addr_t'(ir_q[IMM_W-1:0]);
            ADDR_REG2: mem_addr = addr_t'(rdata2);
            default:   mem_addr = pc_q;
        endcase

        case (ctrl.data_src)
            DATA_MEM: reg_wdata = mem_rdata;
            DATA_ALU: reg_wdata = alu_q;
            default:  reg_wdata = word_t'(ir_q[IMM_W-1:0]);    // Zero-extended
        endcase

        case (ctrl.pc_src)
            PC_REG:  pc_next = addr_t'(rdata1);
            PC_LINK: pc_next = link_q;
            default: pc_next = pc_rel;
        endcase
    end

    // --------------------------------------------------
    // Registers
    // --------------------------------------------------
    always_ff @(posedge Clk) begin
        if (reset) begin
            pc_q  <= '0;
            flg_q <= '0;
        end else begin
            if (ctrl.pc_ld) begin
                pc_q <= pc_next;
            end else if (ctrl.pc_inc) begin
                pc_q <= pc_q + 1'b1;
            end

            if (ctrl.flg_rst) begin
                flg_q <= '0;
            end else if (ctrl.flg_ld) begin
                flg_q <= alu_flags;
            end
        end
    end

    // Payload registers
    always_ff @(posedge Clk) begin
        if (ctrl.ir_ld)   ir_q   <= mem_rdata;
        if (ctrl.link_ld) link_q <= pc_q;       // Address after the call
        if (ctrl.alu_ld)  alu_q  <= alu_result;
    end

    reg_file u_reg_file (
        .Clk    (Clk),
        .we     (ctrl.reg_we),
        .waddr  (dest),
        .wdata  (reg_wdata),
        .raddr1 (raddr1),
        .raddr2 (src2),
        .rdata1 (rdata1),
        .rdata2 (rdata2)
    );

    alu u_alu (
        .a      (rdata1),
        .b      (rdata2),
        .op     (ctrl.alu_op),
        .result (alu_result),
        .flags  (alu_flags)
    );

endmodule

`default_nettype wire

// File: logic/cpu_top.sv
`timescale 1ns/100ps
`default_nettype none

module cpu_top import isa_pkg::*; (
    input  wire logic  Clk,
    input  wire logic  reset,
    // Memory bus, one-cycle read latency
    output logic       mem_en,
    output logic       mem_we,
    output addr_t      mem_addr,
    output word_t      mem_wdata,
    input  wire word_t mem_rdata,
    output logic       halted      // High in IDLE until reset
);

    cpu_ctrl_if ctrl ();

    // --------------------------------------------------
    // Control and data halves
    // --------------------------------------------------
    sequence_control u_sequence_control (
        .Clk    (Clk),
        .reset  (reset),
        .ctrl   (ctrl),
        .halted (halted)
    );

    cpu_datapath u_cpu_datapath (
        .Clk       (Clk),
        .reset     (reset),
        .ctrl      (ctrl),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_rdata (mem_rdata)
    );

    // Bus strobes come straight from the sequencer
    assign mem_en = ctrl.mem_en;
    assign mem_we = ctrl.mem_we;

endmodule

`default_nettype wire

// File: bench/cpu_assertions.sv
`timescale 1ns/100ps
`default_nettype none

module cpu_assertions (
    input wire logic Clk,
    input wire logic reset,
    input wire logic mem_en,
    input wire logic mem_we,
    input wire logic halted
);

    // --------------------------------------------------
    // Bus strobes
    // --------------------------------------------------
    property write_needs_enable;
        @(posedge Clk) disable iff (reset)
        mem_we |-> mem_en;
    endproperty

    // No fetch or data access once in IDLE
    property quiet_when_halted;
        @(posedge Clk) disable iff (reset)
        halted |-> !mem_en;
    endproperty

    // IDLE is left only through reset
    property halt_is_sticky;
        @(posedge Clk) disable iff (reset)
        $past(halted) |-> halted;
    endproperty

    a_write_needs_enable: assert property (write_needs_enable)
        else $error("mem_we high while mem_en is low");

    a_quiet_when_halted: assert property (quiet_when_halted)
        else $error("Bus access while halted");

    a_halt_is_sticky: assert property (halt_is_sticky)
        else $error("halted fell without a reset");

endmodule

bind cpu_top cpu_assertions u_cpu_assertions (
    .Clk    (Clk),
    .reset  (reset),
    .mem_en (mem_en),
    .mem_we (mem_we),
    .halted (halted)
);

`default_nettype wire

// File: bench/cpu_tb.sv
`timescale 1ns/100ps
`default_nettype none

module cpu_tb import isa_pkg::*; ();

    localparam int MEM_WORDS        = 256;
    localparam int CLK_PERIOD_NS    = 100;
    localparam int RESET_CYCLES     = 16;
    localparam int HOLD_CYCLES      = 50;     // Quiet window after HLT
    localparam int TEST_COUNT       = 5;
    localparam int INSTR_PER_TEST   = 300;
    localparam int CYCLES_PER_INSTR = 4;      // LD and ALU ops, the slowest
    localparam longint WATCHDOG_NS  =
        longint'(TEST_COUNT) * INSTR_PER_TEST * CYCLES_PER_INSTR * CLK_PERIOD_NS;

    // Marker immediates, 9 bits
    localparam int TAKEN_MARK = 'h1a0;
    localparam int FALL_MARK  = 'h0f0;
    localparam int CLEAR_MARK = 'h150;
    localparam int BRX_MARK   = 'h0c3;
    localparam int SUB_MARK   = 'h111;
    localparam int JMP_MARK   = 'h122;
    localparam int RET_MARK   = 'h133;
    localparam int BAD_MARK   = 'h1ff;
    localparam int SEQ_BASE   = 244;      // Call test result words

    logic        Clk = 1'b0;
    logic        reset = 1'b1;
    logic        mem_en;
    logic        mem_we;
    addr_t       mem_addr;
    word_t       mem_wdata;
    word_t       mem_rdata = '0;
    logic        halted;

    word_t       mem [MEM_WORDS];       // Memory model
    word_t       exp_mem [MEM_WORDS];   // Expected image
    word_t       read_word = '0;
    addr_t       last_fetch = '0;
    logic        expect_data_read = 1'b0;   // Next read is an LD operand
    int          write_count = 0;
    int          load_ptr = 0;
    logic [31:0] rng_state = 32'h3cb0_0480;

    always #(CLK_PERIOD_NS / 2) Clk = ~Clk;

    cpu_top u_dut (
        .Clk       (Clk),
        .reset     (reset),
        .mem_en    (mem_en),
        .mem_we    (mem_we),
        .mem_addr  (mem_addr),
        .mem_wdata (mem_wdata),
        .mem_rdata (mem_rdata),
        .halted    (halted)
    );

    // --------------------------------------------------
    // Memory model, one-cycle read latency
    // --------------------------------------------------
    always @(posedge Clk) begin
        if (reset) begin
            expect_data_read <= 1'b0;
        end else if (mem_en) begin
            if (mem_addr >= MEM_WORDS) begin
                stop_with_failure($sformatf("Bus access at %h is outside memory", mem_addr));
            end
            if (mem_we) begin
                mem[mem_addr[7:0]] = mem_wdata;
                write_count        <= write_count + 1;
            end else begin
                read_word <= mem[mem_addr[7:0]];
                if (expect_data_read) begin
                    expect_data_read <= 1'b0;   // Operand of an LD
                end else begin
                    last_fetch       <= mem_addr;
                    expect_data_read <= (mem[mem_addr[7:0]][15:12] == OP_LD);
                end
            end
        end
    end

    always @(negedge Clk) mem_rdata <= read_word;   // Word valid through the next edge

    // --------------------------------------------------
    // Reporting and compare tasks
    // --------------------------------------------------
    task automatic stop_with_failure(input string reason);
        $display("%s", reason);
        $display("Something failed");
        $fatal(1, "Run stopped at the first error");
    endtask

    task automatic check_word(input string name, input word_t got, input word_t expected);
        if (got !== expected) begin
            stop_with_failure($sformatf("FAIL at %0t: %s got %h, expected %h",
                                        $time, name, got, expected));
        end
    endtask

    task automatic check_addr(input string name, input addr_t got, input addr_t expected);
        if (got !== expected) begin
            stop_with_failure($sformatf("FAIL at %0t: %s got %h, expected %h",
                                        $time, name, got, expected));
        end
    endtask

    // --------------------------------------------------
    // Stimulus helpers
    // --------------------------------------------------
    function automatic logic [31:0] xorshift32(input logic [31:0] x);
        logic [31:0] y;
        y = x ^ (x << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic word_t random_word();
        rng_state = xorshift32(rng_state);
        return rng_state[15:0];
    endfunction

    // Background word, differs for every address
    function automatic word_t fill_word(input int a);
        word_t w;
        w = word_t'(a);
        return {~w[7:0], w[7:0]} ^ 16'h5a3c;
    endfunction

    // op | dest | 00 | src1 | 0 | src2
    function automatic word_t reg_form(input opcode_e op, input reg_sel_t d,
                                       input reg_sel_t s1, input reg_sel_t s2);
        return {op, d, 2'b00, s1, 1'b0, s2};
    endfunction

    function automatic word_t imm_form(input opcode_e op, input reg_sel_t d,
                                       input logic [8:0] imm);
        return {op, d, imm};
    endfunction

    function automatic word_t branch_form(input opcode_e op, input branch_cond_e cond,
                                          input logic [9:0] offset);
        return {op, cond, offset};
    endfunction

    task automatic start_program();
        for (int i = 0; i < MEM_WORDS; i++) begin
            mem[i]     = fill_word(i);
            exp_mem[i] = mem[i];
        end
        load_ptr = 0;
    endtask

    task automatic emit(input word_t w);
        mem[load_ptr]     = w;
        exp_mem[load_ptr] = w;
        load_ptr++;
    endtask

    task automatic place_data(input int a, input word_t w);
        mem[a]     = w;
        exp_mem[a] = w;
    endtask

    task automatic expect_store(input int a, input word_t w);
        exp_mem[a] = w;
    endtask

    task automatic check_memory();
        for (int i = 0; i < MEM_WORDS; i++) begin
            check_word($sformatf("mem[%0d]", i), mem[i], exp_mem[i]);
        end
    endtask

    // Reset, run to HLT, then compare fetch address and memory
    task automatic run_program(input addr_t halt_addr);
        @(negedge Clk);
        reset = 1'b1;
        repeat (RESET_CYCLES) @(negedge Clk);
        reset = 1'b0;
        while (halted !== 1'b1) @(negedge Clk);
        check_addr("last fetch address", last_fetch, halt_addr);
        check_memory();
    endtask

    // --------------------------------------------------
    // Directed tests
    // --------------------------------------------------
    task automatic load_and_store_immediates();
        word_t      w;
        logic [8:0] imm [8];
        int         halt_at;
        start_program();
        for (int r = 0; r < 8; r++) begin
            w      = random_word();
            imm[r] = w[8:0];
            emit(imm_form(OP_LDI, reg_sel_t'(r), imm[r]));
        end
        for (int r = 0; r < 8; r++) begin
            emit(imm_form(OP_ST, reg_sel_t'(r), 9'(200 + r)));
            expect_store(200 + r, {7'b0, imm[r]});  // Zero-extended
        end
        halt_at = load_ptr;
        emit(reg_form(OP_HLT, 3'd0, 3'd0, 3'd0));
        run_program(addr_t'(halt_at));
    endtask

    task automatic run_alu_operations();
        opcode_e ops [5];
        word_t   a;
        word_t   b;
        word_t   expected;
        int      halt_at;
        ops = '{OP_ADD, OP_SUB, OP_AND, OP_OR, OP_XOR};
        start_program();
        for (int r = 0; r < 3; r++) begin
            a = random_word();
            b = random_word();
            place_data(160 + 2 * r, a);
            place_data(161 + 2 * r, b);
            emit(imm_form(OP_LD, 3'd1, 9'(160 + 2 * r)));
            emit(imm_form(OP_LD, 3'd2, 9'(161 + 2 * r)));
            for (int k = 0; k < 5; k++) begin
                emit(reg_form(ops[k], reg_sel_t'(3 + k), 3'd1, 3'd2));  // r3..r7
            end
            for (int k = 0; k < 5; k++) begin
                case (ops[k])
                    OP_ADD:  expected = a + b;      // Truncated to 16 bits
                    OP_SUB:  expected = a - b;
                    OP_AND:  expected = a & b;
                    OP_OR:   expected = a | b;
                    default: expected = a ^ b;
                endcase
                emit(imm_form(OP_ST, reg_sel_t'(3 + k), 9'(170 + 5 * r + k)));
                expect_store(170 + 5 * r + k, expected);
            end
        end
        halt_at = load_ptr;
        emit(reg_form(OP_HLT, 3'd0, 3'd0, 3'd0));
        run_program(addr_t'(halt_at));
    endtask

    task automatic branch_on_conditions();
        branch_cond_e cond;
        word_t        a;
        word_t        b;
        logic         taken;
        int           target;
        int           halt_at;
        start_program();
        for (int k = 0; k < 8; k++) begin
            cond = branch_cond_e'(k % 4);
            a    = random_word();
            b    = random_word();
            if (k >= 4 && (cond == BEQ || cond == BNE))
                b = a;                                  // Zero result in round two
            case (cond)
                BEQ:     taken = (a == b);
                BNE:     taken = (a != b);
                BLT:     taken = ($signed(a) < $signed(b));
                default: taken = (a < b);               // Borrow
            endcase
            place_data(200 + 2 * k, a);
            place_data(201 + 2 * k, b);
            emit(imm_form(OP_LD, 3'd1, 9'(200 + 2 * k)));
            emit(imm_form(OP_LD, 3'd2, 9'(201 + 2 * k)));
            emit(reg_form(OP_SUB, 3'd3, 3'd1, 3'd2));
            emit(imm_form(OP_LDI, 3'd4, 9'(TAKEN_MARK + k)));
            emit(imm_form(OP_LDI, 3'd6, 9'd0));
            emit(branch_form(OP_BRD, cond, 10'd1));         // Taken skips one word
            emit(imm_form(OP_LDI, 3'd4, 9'(FALL_MARK + k)));
            emit(branch_form(OP_BRD, BEQ, 10'd1));          // Flags now clear
            emit(imm_form(OP_LDI, 3'd6, 9'(CLEAR_MARK + k)));
            emit(imm_form(OP_LDI, 3'd7, 9'(220 + k)));
            emit(reg_form(OP_STX, 3'd4, 3'd0, 3'd7));
            emit(imm_form(OP_LDI, 3'd7, 9'(230 + k)));
            emit(reg_form(OP_STX, 3'd6, 3'd0, 3'd7));
            expect_store(220 + k, word_t'(taken ? TAKEN_MARK + k : FALL_MARK + k));
            expect_store(230 + k, word_t'(CLEAR_MARK + k));
        end

        // BRX to a target held in r5
        emit(imm_form(OP_LDI, 3'd1, 9'h055));
        emit(imm_form(OP_LDI, 3'd2, 9'h055));
        emit(reg_form(OP_SUB, 3'd3, 3'd1, 3'd2));   // z set
        target = load_ptr + 4;
        emit(imm_form(OP_LDI, 3'd5, 9'(target)));
        emit(imm_form(OP_LDI, 3'd4, 9'(BRX_MARK)));
        emit(reg_form(OP_BRX, {BEQ, 1'b0}, 3'd5, 3'd0));
        emit(imm_form(OP_LDI, 3'd4, 9'(FALL_MARK)));   // Skipped when taken
        emit(imm_form(OP_LDI, 3'd7, 9'd240));
        emit(reg_form(OP_STX, 3'd4, 3'd0, 3'd7));
        expect_store(240, word_t'(BRX_MARK));
        halt_at = load_ptr;
        emit(reg_form(OP_HLT, 3'd0, 3'd0, 3'd0));
        run_program(addr_t'(halt_at));
    endtask

    task automatic call_and_return();
        start_program();
        // Main line, words 0 to 7
        emit(imm_form(OP_LDI, 3'd1, 9'd8));        // Subroutine entry
        emit(imm_form(OP_LDI, 3'd2, 9'd15));       // JMP target
        emit(imm_form(OP_LDI, 3'd6, 9'(SEQ_BASE)));
        emit(reg_form(OP_JPL, 3'd0, 3'd1, 3'd0));  // Call, link is 4
        emit(imm_form(OP_LDI, 3'd4, 9'(RET_MARK)));
        emit(imm_form(OP_LDI, 3'd5, 9'(SEQ_BASE + 2)));
        emit(reg_form(OP_STX, 3'd4, 3'd0, 3'd5));
        emit(reg_form(OP_HLT, 3'd0, 3'd0, 3'd0));  // Word 7
        // Subroutine, words 8 to 14
        emit(imm_form(OP_LDI, 3'd4, 9'(SUB_MARK)));
        emit(reg_form(OP_STX, 3'd4, 3'd0, 3'd6));
        emit(reg_form(OP_JPL, 3'b100, 3'd2, 3'd0)); // JMP, no link
        emit(imm_form(OP_LDI, 3'd4, 9'(BAD_MARK)));  // Only if JMP linked
        emit(imm_form(OP_LDI, 3'd5, 9'(SEQ_BASE + 3)));
        emit(reg_form(OP_STX, 3'd4, 3'd0, 3'd5));
        emit(reg_form(OP_HLT, 3'd0, 3'd0, 3'd0));
        // JMP target, words 15 to 18
        emit(imm_form(OP_LDI, 3'd4, 9'(JMP_MARK)));
        emit(imm_form(OP_LDI, 3'd5, 9'(SEQ_BASE + 1)));
        emit(reg_form(OP_STX, 3'd4, 3'd0, 3'd5));
        emit(reg_form(OP_RET, 3'd0, 3'd0, 3'd0));
        expect_store(SEQ_BASE, word_t'(SUB_MARK));
        expect_store(SEQ_BASE + 1, word_t'(JMP_MARK));
        expect_store(SEQ_BASE + 2, word_t'(RET_MARK));
        run_program(addr_t'(7));
    endtask

    task automatic halt_and_hold();
        int halt_at;
        int writes_before;
        start_program();
        emit(reg_form(OP_NOP, 3'd0, 3'd0, 3'd0));
        emit(imm_form(OP_LDI, 3'd1, 9'h0a5));
        emit(imm_form(OP_ST, 3'd1, 9'd250));
        emit(reg_form(OP_NOP, 3'd0, 3'd0, 3'd0));
        halt_at = load_ptr;
        emit(reg_form(OP_HLT, 3'd0, 3'd0, 3'd0));
        emit(imm_form(OP_ST, 3'd1, 9'd251));       // Never reached
        expect_store(250, 16'h00a5);
        run_program(addr_t'(halt_at));
        writes_before = write_count;
        repeat (HOLD_CYCLES) begin
            @(negedge Clk);
            if (halted !== 1'b1)
                stop_with_failure("halted dropped while no reset was applied");
        end
        if (write_count != writes_before)
            stop_with_failure("A store appeared on the bus after HLT");
        check_addr("last fetch address after hold", last_fetch, addr_t'(halt_at));
        check_memory();
    endtask

    // --------------------------------------------------
    // Main sequence and watchdog
    // --------------------------------------------------
    initial begin
        load_and_store_immediates();
        run_alu_operations();
        branch_on_conditions();
        call_and_return();
        halt_and_hold();
        $display("Everything OK");
        $finish;
    end

    initial begin
        #(WATCHDOG_NS);
        stop_with_failure("Run timed out before all tests finished");
    end

endmodule

`default_nettype wire

// File: list.f
+incdir+common
common/isa_pkg.sv
common/ctrl_pkg.sv
common/cpu_ctrl_if.sv
logic/reg_file.sv
logic/alu.sv
sequencer/sequence_control.sv
datapath/cpu_datapath.sv
logic/cpu_top.sv
bench/cpu_assertions.sv
bench/cpu_tb.sv

// File: run.sh
#!/bin/sh
# Build and run the CPU testbench with Verilator

cd "$(dirname "$0")" || exit 1

LOG=sim.log

if ! verilator --binary --timing --assert -Wno-fatal \
        --top-module cpu_tb -f list.f -o cpu_sim; then
    echo "Verilator build failed"
    exit 1
fi

if ! ./obj_dir/cpu_sim > "$LOG" 2>&1; then
    cat "$LOG"
    echo "Simulation exited with an error status"
    exit 1
fi
cat "$LOG"

if grep -q "Everything OK" "$LOG"; then
    exit 0
fi
echo "Pass message not found in $LOG"
exit 1
